// File: rtl/commit_macros.svh
`ifndef COMMIT_MACROS_SVH
`define COMMIT_MACROS_SVH

// ----------------------------------------------------------
// datapath widths
// ----------------------------------------------------------

// integer and fp register width, also csr data width
`define COMMIT_XLEN 64

// virtual address width of the pc
`define COMMIT_VLEN 64

// scoreboard transaction id
`define COMMIT_TRANS_ID_BITS 3

// ----------------------------------------------------------
// retirement shape
// ----------------------------------------------------------

// port 0 retires anything, port 1 only simple ops
`define COMMIT_NR_PORTS 2

// accrued fp exception flags: nv dz of uf nx
`define COMMIT_FFLAGS_BITS 5

// encoding width of the operation field
// shared by op_t and the csr command word
`define COMMIT_OP_BITS 6

`endif

// File: rtl/commit_ctrl_pkg.sv
`include "commit_macros.svh"

package commit_ctrl_pkg;

    // ----------------------------------------------------------
    // exception cause word
    // ----------------------------------------------------------

    // accrued fp flags in fflags csr bit order
    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    // trap view, msb flags an interrupt
    typedef struct packed {
        logic                     interrupt;
        logic [`COMMIT_XLEN-2:0]  code;
    } exc_trap_t;

    // fp view, flags live in the low bits of the cause
    typedef struct packed {
        logic [`COMMIT_XLEN-`COMMIT_FFLAGS_BITS-1:0] pad;
        fflags_t                                     flags;
    } exc_fp_t;

    // one word, read as a trap cause or as fpu flags
    typedef union packed {
        exc_trap_t trap;
        exc_fp_t   fp;
    } exc_cause_u;

    typedef struct packed {
        logic                    valid;
        exc_cause_u              cause;
        logic [`COMMIT_XLEN-1:0] tval;
    } exception_t;

    // ----------------------------------------------------------
    // side effects toward controller and csr file
    // ----------------------------------------------------------

    // one bit per fence flavour, each implies a pipeline flush
    typedef struct packed {
        logic fence;
        logic fence_i;
        logic sfence_vma;
    } fence_req_t;

    // op holds an op_t encoding from the instruction package
    typedef struct packed {
        logic [`COMMIT_OP_BITS-1:0] op;
        logic [`COMMIT_XLEN-1:0]    wdata;
    } csr_cmd_t;

endpackage

// File: rtl/commit_instr_pkg.sv
`include "commit_macros.svh"

package commit_instr_pkg;

    import commit_ctrl_pkg::*;

    // ----------------------------------------------------------
    // functional unit and operation
    // ----------------------------------------------------------

    typedef enum logic [2:0] {
        ALU,
        LOAD,
        STORE,
        CTRL_FLOW,
        MULT,
        CSR,
        FPU
    } fu_t;

    // ADD doubles as the csr no-op
    typedef enum logic [`COMMIT_OP_BITS-1:0] {
        ADD,
        SUB,
        XORL,
        ORL,
        ANDL,
        SLL,
        SRL,
        SRA,
        SLTS,
        SLTU,
        MUL,
        DIV,
        LD,
        SD,
        JALR,
        BEQ,
        CSR_RW,
        CSR_RS,
        CSR_RC,
        FENCE,
        FENCE_I,
        SFENCE_VMA,
        FADD,
        FMUL,
        FLD,
        // fp source but integer destination
        FMV_X_D
    } op_t;

    // ----------------------------------------------------------
    // scoreboard entry
    // ----------------------------------------------------------

    typedef struct packed {
        logic                             valid;
        logic [`COMMIT_VLEN-1:0]          pc;
        fu_t                              fu;
        op_t                              op;
        logic [4:0]                       rd;
        logic [`COMMIT_XLEN-1:0]          result;
        logic [`COMMIT_TRANS_ID_BITS-1:0] trans_id;
        // for fpu ops cause carries the flags, valid stays low
        exception_t                       ex;
    } commit_entry_t;

    // destination is the fp register file
    function automatic logic is_rd_fpr(op_t op);
        return op inside {FADD, FMUL, FLD};
    endfunction

endpackage

// File: rtl/commit_port0.sv
`timescale 1ns/1ps
`include "commit_macros.svh"

module commit_port0 import commit_ctrl_pkg::*, commit_instr_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  commit_entry_t           instr0_i,
    input  logic                    halt_i,
    input  logic                    commit_lsu_ready_i,
    input  logic                    no_st_pending_i,
    input  logic [`COMMIT_XLEN-1:0] csr_rdata_i,
    input  logic                    csr_exception_valid_i,
    output logic                    ack0_o,
    output logic                    we_gpr0_o,
    output logic                    we_fpr0_o,
    output logic [`COMMIT_XLEN-1:0] wdata0_o,
    output logic                    commit_lsu_o,
    output logic                    commit_csr_o,
    output csr_cmd_t                csr_cmd_o,
    output fence_req_t              fence_req_o,
    output logic                    instr0_blocks_dual_o
);

    logic retire_ok;
    logic is_store;
    logic is_csr;
    logic rd_fpr;

    // oldest entry may go unless faulting or halted
    assign retire_ok = instr0_i.valid && !instr0_i.ex.valid && !halt_i;
    assign is_store  = (instr0_i.fu == STORE);
    assign is_csr    = (instr0_i.fu == CSR);
    assign rd_fpr    = is_rd_fpr(instr0_i.op);

    // csr side effects must be seen before anything younger retires
    assign instr0_blocks_dual_o = is_csr;

    // ----------------------------------------------------------
    // retirement decision
    // ----------------------------------------------------------
    always_comb begin
        ack0_o          = 1'b0;
        wdata0_o        = instr0_i.result;
        commit_lsu_o    = 1'b0;
        commit_csr_o    = 1'b0;
        // idle csr file sees a no-op
        csr_cmd_o.op    = ADD;
        csr_cmd_o.wdata = '0;
        fence_req_o     = '0;

        if (retire_ok) begin
            ack0_o = 1'b1;

            // store sits in the scoreboard until the lsu takes it
            if (is_store) begin
                ack0_o       = commit_lsu_ready_i;
                commit_lsu_o = commit_lsu_ready_i;
            end

            // csr op is presented every cycle, committed only if clean
            if (is_csr) begin
                csr_cmd_o.op    = instr0_i.op;
                csr_cmd_o.wdata = instr0_i.result;
                ack0_o          = !csr_exception_valid_i;
                commit_csr_o    = !csr_exception_valid_i;
                if (!csr_exception_valid_i) begin
                    // old csr value goes to rd
                    wdata0_o = csr_rdata_i;
                end
            end

            // fences wait for the store buffer to drain
            if (instr0_i.op == FENCE) begin
                ack0_o            = no_st_pending_i;
                fence_req_o.fence = no_st_pending_i;
            end else if (instr0_i.op == FENCE_I) begin
                ack0_o              = no_st_pending_i;
                fence_req_o.fence_i = no_st_pending_i;
            end else if (instr0_i.op == SFENCE_VMA) begin
                ack0_o                 = no_st_pending_i;
                fence_req_o.sfence_vma = no_st_pending_i;
            end
        end
    end

    // write only what really retires
    assign we_fpr0_o = ack0_o && rd_fpr;
    assign we_gpr0_o = ack0_o && !rd_fpr;

    // ----------------------------------------------------------
    // checks
    // ----------------------------------------------------------

    // lsu release and scoreboard ack go together
    lsu_release_is_store: assert property (
        @(posedge clk_i) disable iff (rst_i)
        commit_lsu_o |-> (is_store && ack0_o)
    ) else $error("commit_lsu_o without a retiring store");

    // flush only after the store buffer is empty
    fence_after_drain: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (|fence_req_o) |-> no_st_pending_i
    ) else $error("fence request while stores are pending");

endmodule

// File: rtl/commit_port1.sv
`timescale 1ns/1ps

module commit_port1 import commit_instr_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_i,
    input  commit_entry_t instr1_i,
    input  logic          ack0_i,
    input  logic          instr0_blocks_dual_i,
    input  logic          exception_valid_i,
    input  logic          halt_i,
    input  logic          single_step_i,
    output logic          ack1_o,
    output logic          we_gpr1_o,
    output logic          we_fpr1_o
);

    logic simple_fu;
    logic entry_ok;
    logic pair_ok;
    logic rd_fpr;

    // units without side effects outside the register file
    // stores, csr ops and fences stay on port 0
    assign simple_fu = instr1_i.fu inside {ALU, LOAD, CTRL_FLOW, MULT, FPU};

    assign entry_ok = instr1_i.valid && !instr1_i.ex.valid && simple_fu;

    // conditions coming from port 0 and the debug state
    assign pair_ok = ack0_i
                  && !halt_i
                  && !single_step_i
                  && !instr0_blocks_dual_i
                  && !exception_valid_i;

    assign ack1_o = pair_ok && entry_ok;

    assign rd_fpr    = is_rd_fpr(instr1_i.op);
    assign we_fpr1_o = ack1_o && rd_fpr;
    assign we_gpr1_o = ack1_o && !rd_fpr;

    // ----------------------------------------------------------
    // checks
    // ----------------------------------------------------------

    // retirement stays in order across the two ports
    in_order_retire: assert property (
        @(posedge clk_i) disable iff (rst_i)
        ack1_o |-> ack0_i
    ) else $error("port 1 acked without port 0");

endmodule

// File: rtl/commit_fp_status.sv
`timescale 1ns/1ps
`include "commit_macros.svh"

module commit_fp_status import commit_ctrl_pkg::*, commit_instr_pkg::*; (
    input  commit_entry_t [`COMMIT_NR_PORTS-1:0] instr_i,
    input  logic          [`COMMIT_NR_PORTS-1:0] ack_i,
    output logic                                 csr_write_fflags_o,
    output fflags_t                              csr_fflags_o,
    output logic                                 dirty_fp_state_o
);

    logic [`COMMIT_FFLAGS_BITS-1:0] flags_acc;

    // ----------------------------------------------------------
    // flag merge over retiring entries
    // ----------------------------------------------------------
    always_comb begin
        csr_write_fflags_o = 1'b0;
        dirty_fp_state_o   = 1'b0;
        flags_acc          = '0;
        for (int i = 0; i < `COMMIT_NR_PORTS; i++) begin
            // fpu results bring their flags in the cause word
            if (ack_i[i] && instr_i[i].fu == FPU) begin
                csr_write_fflags_o = 1'b1;
                flags_acc          = flags_acc | instr_i[i].ex.cause.fp.flags;
            end
            // fp loads touch fp state too, FMV_X_D via the fpu unit
            if (ack_i[i] && (instr_i[i].fu == FPU || is_rd_fpr(instr_i[i].op))) begin
                dirty_fp_state_o = 1'b1;
            end
        end
    end

    // flags are accrued, the csr file ORs them in
    assign csr_fflags_o = fflags_t'(flags_acc);

endmodule

// File: rtl/commit_exception.sv
`timescale 1ns/1ps

module commit_exception import commit_ctrl_pkg::*, commit_instr_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_i,
    input  commit_entry_t instr0_i,
    input  exception_t    csr_exception_i,
    input  logic          halt_i,
    output exception_t    exception_o
);

    // ----------------------------------------------------------
    // exception priority
    // ----------------------------------------------------------
    // interrupts already ordered inside the csr file
    // here an earlier pipeline fault beats the csr one
    always_comb begin
        exception_o = '0;
        if (instr0_i.valid) begin
            if (instr0_i.ex.valid) begin
                // fault from fetch, decode or execute
                exception_o = instr0_i.ex;
            end else if (csr_exception_i.valid) begin
                exception_o      = csr_exception_i;
                // entry still holds the faulting instruction bits
                exception_o.tval = instr0_i.ex.tval;
            end
        end
        // halted core takes no trap
        if (halt_i) begin
            exception_o.valid = 1'b0;
        end
    end

    // ----------------------------------------------------------
    // checks
    // ----------------------------------------------------------

    // a trap always belongs to the oldest scoreboard entry
    trap_has_entry: assert property (
        @(posedge clk_i) disable iff (rst_i)
        exception_o.valid |-> instr0_i.valid
    ) else $error("exception reported without a valid entry 0");

endmodule

// File: rtl/commit_stage.sv
`timescale 1ns/1ps
`include "commit_macros.svh"

module commit_stage import commit_ctrl_pkg::*, commit_instr_pkg::*; (
    input  logic                                      clk_i,
    input  logic                                      rst_i,
    input  logic                                      halt_i,
    input  logic                                      single_step_i,
    // scoreboard
    input  commit_entry_t [`COMMIT_NR_PORTS-1:0]      commit_instr_i,
    output logic          [`COMMIT_NR_PORTS-1:0]      commit_ack_o,
    output logic          [`COMMIT_TRANS_ID_BITS-1:0] commit_tran_id_o,
    // register files
    output logic [`COMMIT_NR_PORTS-1:0][4:0]              waddr_o,
    output logic [`COMMIT_NR_PORTS-1:0][`COMMIT_XLEN-1:0] wdata_o,
    output logic [`COMMIT_NR_PORTS-1:0]                   we_gpr_o,
    output logic [`COMMIT_NR_PORTS-1:0]                   we_fpr_o,
    // lsu
    input  logic                                      commit_lsu_ready_i,
    input  logic                                      no_st_pending_i,
    output logic                                      commit_lsu_o,
    // csr file
    output csr_cmd_t                                  csr_cmd_o,
    output logic                                      commit_csr_o,
    input  logic [`COMMIT_XLEN-1:0]                   csr_rdata_i,
    input  exception_t                                csr_exception_i,
    output logic                                      csr_write_fflags_o,
    output fflags_t                                   csr_fflags_o,
    // controller
    output exception_t                                exception_o,
    output fence_req_t                                fence_req_o,
    output logic                                      dirty_fp_state_o,
    output logic [`COMMIT_VLEN-1:0]                   pc_o
);

    logic instr0_blocks_dual;

    // ----------------------------------------------------------
    // plain routing from the scoreboard
    // ----------------------------------------------------------
    for (genvar i = 0; i < `COMMIT_NR_PORTS; i++) begin : gen_waddr
        assign waddr_o[i] = commit_instr_i[i].rd;
    end

    // port 1 never sees csr data
    assign wdata_o[1]       = commit_instr_i[1].result;
    assign pc_o             = commit_instr_i[0].pc;
    assign commit_tran_id_o = commit_instr_i[0].trans_id;

    // ----------------------------------------------------------
    // retirement blocks
    // ----------------------------------------------------------
    commit_port0 u_port0 (
        .clk_i                (clk_i),
        .rst_i                (rst_i),
        .instr0_i             (commit_instr_i[0]),
        .halt_i               (halt_i),
        .commit_lsu_ready_i   (commit_lsu_ready_i),
        .no_st_pending_i      (no_st_pending_i),
        .csr_rdata_i          (csr_rdata_i),
        .csr_exception_valid_i(csr_exception_i.valid),
        .ack0_o               (commit_ack_o[0]),
        .we_gpr0_o            (we_gpr_o[0]),
        .we_fpr0_o            (we_fpr_o[0]),
        .wdata0_o             (wdata_o[0]),
        .commit_lsu_o         (commit_lsu_o),
        .commit_csr_o         (commit_csr_o),
        .csr_cmd_o            (csr_cmd_o),
        .fence_req_o          (fence_req_o),
        .instr0_blocks_dual_o (instr0_blocks_dual)
    );

    // dual retire also blocked by any reported trap
    commit_port1 u_port1 (
        .clk_i               (clk_i),
        .rst_i               (rst_i),
        .instr1_i            (commit_instr_i[1]),
        .ack0_i              (commit_ack_o[0]),
        .instr0_blocks_dual_i(instr0_blocks_dual),
        .exception_valid_i   (exception_o.valid),
        .halt_i              (halt_i),
        .single_step_i       (single_step_i),
        .ack1_o              (commit_ack_o[1]),
        .we_gpr1_o           (we_gpr_o[1]),
        .we_fpr1_o           (we_fpr_o[1])
    );

    commit_fp_status u_fp_status (
        .instr_i           (commit_instr_i),
        .ack_i             (commit_ack_o),
        .csr_write_fflags_o(csr_write_fflags_o),
        .csr_fflags_o      (csr_fflags_o),
        .dirty_fp_state_o  (dirty_fp_state_o)
    );

    commit_exception u_exception (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .instr0_i       (commit_instr_i[0]),
        .csr_exception_i(csr_exception_i),
        .halt_i         (halt_i),
        .exception_o    (exception_o)
    );

endmodule

// File: tests/tb_commit_stage.sv
`timescale 1ns/1ps
`include "commit_macros.svh"

module tb_commit_stage import commit_ctrl_pkg::*, commit_instr_pkg::*; ();

    localparam int NUM_DIRECTED = 11;
    localparam int NUM_RANDOM   = 2000;
    localparam int NUM_VECTORS  = NUM_DIRECTED + NUM_RANDOM;

    logic                                       clk;
    logic                                       rst;
    logic                                       halt;
    logic                                       single_step;
    commit_entry_t [`COMMIT_NR_PORTS-1:0]       instr;
    logic          [`COMMIT_NR_PORTS-1:0]       ack;
    logic          [`COMMIT_TRANS_ID_BITS-1:0]  tran_id;
    logic [`COMMIT_NR_PORTS-1:0][4:0]              waddr;
    logic [`COMMIT_NR_PORTS-1:0][`COMMIT_XLEN-1:0] wdata;
    logic [`COMMIT_NR_PORTS-1:0]                   we_gpr;
    logic [`COMMIT_NR_PORTS-1:0]                   we_fpr;
    logic                                       lsu_ready;
    logic                                       no_st_pending;
    logic                                       commit_lsu;
    csr_cmd_t                                   csr_cmd;
    logic                                       commit_csr;
    logic [`COMMIT_XLEN-1:0]                    csr_rdata;
    exception_t                                 csr_exception;
    logic                                       write_fflags;
    fflags_t                                    fflags;
    exception_t                                 exception;
    fence_req_t                                 fence_req;
    logic                                       dirty_fp;
    logic [`COMMIT_VLEN-1:0]                    pc;

    // expected responses rebuilt from the retirement rules
    logic                    base0;
    logic [1:0]              exp_ack;
    exception_t              exp_exc;
    logic [1:0]              exp_we_gpr;
    logic [1:0]              exp_we_fpr;
    logic [`COMMIT_XLEN-1:0] exp_wdata0;
    logic                    exp_lsu;
    logic                    exp_csr;
    csr_cmd_t                exp_csr_cmd;
    fence_req_t              exp_fence;
    logic                    exp_fwrite;
    logic [4:0]              exp_flags;
    logic                    exp_dirty;

    logic [31:0] lfsr_state;
    int          errors;

    commit_stage u_commit_stage (
        .clk_i(clk), .rst_i(rst), .halt_i(halt), .single_step_i(single_step),
        .commit_instr_i(instr), .commit_ack_o(ack), .commit_tran_id_o(tran_id),
        .waddr_o(waddr), .wdata_o(wdata), .we_gpr_o(we_gpr), .we_fpr_o(we_fpr),
        .commit_lsu_ready_i(lsu_ready), .no_st_pending_i(no_st_pending),
        .commit_lsu_o(commit_lsu), .csr_cmd_o(csr_cmd), .commit_csr_o(commit_csr),
        .csr_rdata_i(csr_rdata), .csr_exception_i(csr_exception),
        .csr_write_fflags_o(write_fflags), .csr_fflags_o(fflags),
        .exception_o(exception), .fence_req_o(fence_req),
        .dirty_fp_state_o(dirty_fp), .pc_o(pc)
    );

    // ----------------------------------------------------------
    // reference model
    // ----------------------------------------------------------

    // true for fp register file destinations
    // FMV_X_D lands in the x regs
    function automatic logic writes_fp_file(op_t op);
        return op inside {FADD, FMUL, FLD};
    endfunction

    always_comb begin
        base0 = instr[0].valid && !instr[0].ex.valid && !halt;
        // fences wait for a drained store buffer
        // stores wait for the lsu and csr ops for a clean csr file
        if (!base0)
            exp_ack[0] = 1'b0;
        else if (instr[0].op inside {FENCE, FENCE_I, SFENCE_VMA})
            exp_ack[0] = no_st_pending;
        else if (instr[0].fu == STORE)
            exp_ack[0] = lsu_ready;
        else if (instr[0].fu == CSR)
            exp_ack[0] = !csr_exception.valid;
        else
            exp_ack[0] = 1'b1;
        // own fault beats the csr one
        // csr fault keeps the entry tval
        exp_exc = '0;
        if (instr[0].valid && instr[0].ex.valid) begin
            exp_exc = instr[0].ex;
        end else if (instr[0].valid && csr_exception.valid) begin
            exp_exc.valid = 1'b1;
            exp_exc.cause = csr_exception.cause;
            exp_exc.tval  = instr[0].ex.tval;
        end
        if (halt)
            exp_exc.valid = 1'b0;
        exp_ack[1] = exp_ack[0] && !halt && !single_step && instr[0].fu != CSR
                  && !exp_exc.valid && instr[1].valid && !instr[1].ex.valid
                  && instr[1].fu inside {ALU, LOAD, CTRL_FLOW, MULT, FPU};
        exp_wdata0 = (instr[0].fu == CSR) ? csr_rdata : instr[0].result;
        exp_lsu    = exp_ack[0] && instr[0].fu == STORE;
        exp_csr    = base0 && instr[0].fu == CSR && !csr_exception.valid;
        // idle csr file sees the ADD no-op
        exp_csr_cmd.op    = ADD;
        exp_csr_cmd.wdata = '0;
        if (base0 && instr[0].fu == CSR) begin
            exp_csr_cmd.op    = instr[0].op;
            exp_csr_cmd.wdata = instr[0].result;
        end
        exp_fence.fence      = base0 && instr[0].op == FENCE && no_st_pending;
        exp_fence.fence_i    = base0 && instr[0].op == FENCE_I && no_st_pending;
        exp_fence.sfence_vma = base0 && instr[0].op == SFENCE_VMA && no_st_pending;
        exp_fwrite = 1'b0;
        exp_flags  = '0;
        exp_dirty  = 1'b0;
        for (int i = 0; i < `COMMIT_NR_PORTS; i++) begin
            exp_we_fpr[i] = exp_ack[i] && writes_fp_file(instr[i].op);
            exp_we_gpr[i] = exp_ack[i] && !writes_fp_file(instr[i].op);
            if (exp_ack[i] && instr[i].fu == FPU) begin
                exp_fwrite = 1'b1;
                exp_flags  = exp_flags | instr[i].ex.cause.fp.flags;
            end
            if (exp_ack[i] && (instr[i].fu == FPU || writes_fp_file(instr[i].op)))
                exp_dirty = 1'b1;
        end
    end

    // ----------------------------------------------------------
    // checks
    // ----------------------------------------------------------
    task automatic report_mismatch(string name, logic [128:0] exp, logic [128:0] act);
        errors++;
        $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
    endtask

    ack_chk: assert property (@(posedge clk) disable iff (rst) ack == exp_ack)
        else report_mismatch("ack", exp_ack, ack);
    we_chk: assert property (@(posedge clk) disable iff (rst)
        {we_gpr, we_fpr} == {exp_we_gpr, exp_we_fpr})
        else report_mismatch("we", {exp_we_gpr, exp_we_fpr}, {we_gpr, we_fpr});
    // csr read data replaces the result only on a retiring csr op
    wdata_chk: assert property (@(posedge clk) disable iff (rst)
        (!exp_ack[0] || wdata[0] == exp_wdata0) && wdata[1] == instr[1].result)
        else report_mismatch("wdata", {instr[1].result, exp_wdata0}, wdata);
    route_chk: assert property (@(posedge clk) disable iff (rst)
        {waddr, pc, tran_id} == {instr[1].rd, instr[0].rd, instr[0].pc, instr[0].trans_id})
        else report_mismatch("route", {instr[1].rd, instr[0].rd, instr[0].pc,
            instr[0].trans_id}, {waddr, pc, tran_id});
    side_chk: assert property (@(posedge clk) disable iff (rst)
        {commit_lsu, commit_csr, fence_req} == {exp_lsu, exp_csr, exp_fence})
        else report_mismatch("lsu_csr_fence", {exp_lsu, exp_csr, exp_fence},
            {commit_lsu, commit_csr, fence_req});
    csr_cmd_chk: assert property (@(posedge clk) disable iff (rst) csr_cmd == exp_csr_cmd)
        else report_mismatch("csr_cmd", exp_csr_cmd, csr_cmd);
    exc_chk: assert property (@(posedge clk) disable iff (rst) exception == exp_exc)
        else report_mismatch("exception", exp_exc, exception);
    fp_chk: assert property (@(posedge clk) disable iff (rst)
        {write_fflags, fflags, dirty_fp} == {exp_fwrite, exp_flags, exp_dirty})
        else report_mismatch("fp_status", {exp_fwrite, exp_flags, exp_dirty},
            {write_fflags, fflags, dirty_fp});

    // ----------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------

    // fibonacci lfsr with taps for x^32 + x^22 + x^2 + x + 1
    // stepped once per bit taken
    function automatic logic [63:0] take_bits(int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[62:0], fb};
        end
        return v;
    endfunction

    // kind 0 to 7 selects alu load store ctrl mult csr fence fpu
    function automatic commit_entry_t make_entry(logic [2:0] kind);
        commit_entry_t e;
        logic [1:0]    pick;
        e          = '0;
        pick       = take_bits(2) % 3;
        e.valid    = (take_bits(3) != 0);
        e.pc       = take_bits(64);
        e.rd       = take_bits(5);
        e.result   = take_bits(64);
        e.trans_id = take_bits(3);
        e.ex.valid = (take_bits(3) == 0);
        e.ex.cause = exc_cause_u'(take_bits(64));
        e.ex.tval  = take_bits(64);
        case (kind)
            3'd0: begin
                e.fu = ALU;
                e.op = op_t'(take_bits(4) % 10);
            end
            3'd1: begin
                e.fu = LOAD;
                e.op = pick[0] ? FLD : LD;
            end
            3'd2: begin
                e.fu = STORE;
                e.op = SD;
            end
            3'd3: begin
                e.fu = CTRL_FLOW;
                e.op = pick[0] ? JALR : BEQ;
            end
            3'd4: begin
                e.fu = MULT;
                e.op = pick[0] ? DIV : MUL;
            end
            3'd5: begin
                e.fu = CSR;
                e.op = op_t'(CSR_RW + pick);
            end
            3'd6: begin
                e.fu = CSR;
                e.op = op_t'(FENCE + pick);
            end
            default: begin
                e.fu = FPU;
                e.op = (pick == 0) ? FMV_X_D : op_t'(FADD + pick - 1);
            end
        endcase
        return e;
    endfunction

    task automatic drive_random();
        logic [2:0] k0;
        @(posedge clk);
        #1;
        k0            = take_bits(3);
        instr[0]      = make_entry(k0);
        instr[1]      = make_entry(take_bits(3));
        halt          = (take_bits(4) == 0);
        single_step   = (take_bits(3) == 0);
        lsu_ready     = take_bits(1);
        no_st_pending = take_bits(1);
        csr_rdata     = take_bits(64);
        // csr file only faults on a real csr op
        csr_exception.valid = (k0 == 3'd5) && take_bits(1);
        csr_exception.cause = exc_cause_u'(take_bits(64));
        csr_exception.tval  = take_bits(64);
    endtask

    task automatic set_scenario(logic [2:0] k0, logic [2:0] k1, logic hlt, logic step,
                                logic rdy, logic nost, logic cexc, logic ex0);
        @(posedge clk);
        #1;
        instr[0]          = make_entry(k0);
        instr[0].valid    = 1'b1;
        instr[0].ex.valid = ex0;
        instr[1]          = make_entry(k1);
        instr[1].valid    = 1'b1;
        instr[1].ex.valid = 1'b0;
        halt              = hlt;
        single_step       = step;
        lsu_ready         = rdy;
        no_st_pending     = nost;
        csr_rdata         = take_bits(64);
        csr_exception.valid = cexc;
        csr_exception.cause = exc_cause_u'(take_bits(64));
        csr_exception.tval  = take_bits(64);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(NUM_VECTORS * 8 + 1000);
        $display("watchdog expired before all vectors were applied");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        rst           = 1'b1;
        halt          = 1'b0;
        single_step   = 1'b0;
        instr         = '0;
        lsu_ready     = 1'b0;
        no_st_pending = 1'b1;
        csr_rdata     = '0;
        csr_exception = '0;
        lfsr_state    = 32'h5973_cad8;
        errors        = 0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        set_scenario(3'd0, 3'd1, 0, 0, 1, 1, 0, 0);  // alu and load pair
        set_scenario(3'd2, 3'd2, 0, 0, 0, 1, 0, 0);  // store held by lsu
        set_scenario(3'd2, 3'd0, 0, 0, 1, 1, 0, 0);
        set_scenario(3'd5, 3'd0, 0, 0, 1, 1, 0, 0);  // clean csr op
        set_scenario(3'd5, 3'd0, 0, 0, 1, 1, 1, 0);  // csr file fault
        set_scenario(3'd6, 3'd0, 0, 0, 1, 0, 0, 0);  // fence, stores pending
        set_scenario(3'd6, 3'd0, 0, 0, 1, 1, 0, 0);
        set_scenario(3'd7, 3'd7, 0, 0, 1, 1, 0, 0);  // fpu pair
        set_scenario(3'd0, 3'd0, 1, 0, 1, 1, 0, 0);  // halted
        set_scenario(3'd5, 3'd0, 0, 0, 1, 1, 1, 1);  // own fault over csr fault
        set_scenario(3'd0, 3'd0, 0, 1, 1, 1, 0, 0);  // single step
        repeat (NUM_RANDOM) drive_random();
        // let the last vector be sampled
        @(posedge clk);
        #1;
        $display("%0d errors over %0d vectors", errors, NUM_VECTORS);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: commit_stage.f
+incdir+rtl
rtl/commit_ctrl_pkg.sv
rtl/commit_instr_pkg.sv
rtl/commit_port0.sv
rtl/commit_port1.sv
rtl/commit_fp_status.sv
rtl/commit_exception.sv
rtl/commit_stage.sv
tests/tb_commit_stage.sv

// File: Bender.yml
package:
  name: commit_stage

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/commit_ctrl_pkg.sv
      - rtl/commit_instr_pkg.sv
      - rtl/commit_port0.sv
      - rtl/commit_port1.sv
      - rtl/commit_fp_status.sv
      - rtl/commit_exception.sv
      - rtl/commit_stage.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_commit_stage.sv
